/* src/ex_defs.svh */
// instruction field, opcode/funct and mul/div latency macros, included by decoder, ALU, mul/div and testbench
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// instruction fields
`define OPCODE 31:26
`define RS     25:21
`define RT     20:16
`define RD     15:11
`define SHAMT  10:6
`define FUNCT  5:0
`define IMM    15:0      // sign/zero extension is done upstream

// opcodes
`define OP_SPECIAL 6'b000000   // R-type, look at funct
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define LDST_TOP   2'b10       // loads and stores are 10xxxx, address add

// funct codes, shift group
`define FN_SLL   6'b000000
`define FN_SRL   6'b000010
`define FN_SRA   6'b000011
`define FN_SLLV  6'b000100
`define FN_SRLV  6'b000110
`define FN_SRAV  6'b000111
// funct codes, mul/div group
`define FN_MFHI  6'b010000
`define FN_MTHI  6'b010001
`define FN_MFLO  6'b010010
`define FN_MTLO  6'b010011
`define FN_MULT  6'b011000
`define FN_MULTU 6'b011001
`define FN_DIV   6'b011010
`define FN_DIVU  6'b011011
// funct codes, arithmetic and logic
`define FN_ADDU  6'b100001
`define FN_SUB   6'b100011     // no overflow trap, behaves as subu
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_XOR   6'b100110
`define FN_NOR   6'b100111
`define FN_SLT   6'b101010
`define FN_SLTU  6'b101011

// busy durations of the mul/div unit in cycles
`define MUL_CYCLES 4
`define DIV_CYCLES 12

`endif

/* src/exPkg.sv */
// control enums and packed bundles shared by the execute stage modules, referenced as exPkg::name
`default_nettype none

package exPkg;

    // ALU operation codes 0 to 10
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_NOR  = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SLT  = 4'd10
    } aluOpE;

    typedef enum logic {
        A_RS    = 1'b0,
        A_SHAMT = 1'b1     // zero-extended shamt, constant shifts
    } aSelE;

    // for shifts B is always rt, amount comes through A
    typedef enum logic [1:0] {
        B_RT         = 2'd0,
        B_SHIFTVAR   = 2'd1,  // rt shifted by rs[4:0]
        B_SHIFTCONST = 2'd2,  // rt shifted by shamt
        B_IMM        = 2'd3
    } bSelE;

    typedef enum logic [1:0] {
        RES_ALU    = 2'd0,
        RES_DO     = 2'd1,    // forwarded value already known
        RES_MULDIV = 2'd2     // HI or LO
    } resSelE;

    // bit order follows funct regularity of the mul/div group
    typedef struct packed {
        logic launch;       // mult/multu/div/divu
        logic divide;
        logic isUnsigned;
        logic moveTo;       // mthi/mtlo
        logic targetLo;     // LO side for moves and reads
    } mdCtrlT;

    typedef struct packed {
        aSelE   aSel;
        bSelE   bSel;
        resSelE resSel;
        aluOpE  aluOp;
        mdCtrlT md;
        logic   readsMd;    // mfhi/mflo
    } exCtrlT;

    // ID/EX bundle
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] immExt;
        logic [31:0] doVal;
    } exInT;

    // EX/MEM bundle
    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  dest;
    } exOutT;

endpackage

`default_nettype wire

/* src/exDecode.sv */
// combinational decoder turning the instruction word into the execute control bundle and dest register
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module exDecode (
    input  wire logic [31:0] inst,
    input  wire logic        doReliable,
    output exPkg::exCtrlT    ctrl,
    output logic [4:0]       dest
);
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       special;
    logic       shift;
    logic       mdGroup;

    assign opcode  = inst[`OPCODE];
    assign funct   = inst[`FUNCT];
    assign special = (opcode == `OP_SPECIAL);

    // shift funct is 000xyz with z=arith, y=right, x=variable; 000001/000101 unused
    assign shift   = special && (funct[5:3] == 3'b000) && (funct[1:0] != 2'b01);

    // mul/div group is 0100xx for moves and reads, 0110xx for launches
    assign mdGroup = special && (funct[5:4] == 2'b01) && !funct[2];

    always_comb begin
        ctrl = '0;

        // operand A is shamt only for constant shifts
        if (shift && !funct[2]) begin
            ctrl.aSel = exPkg::A_SHAMT;
        end else begin
            ctrl.aSel = exPkg::A_RS;
        end

        // operand B
        if (shift) begin
            if (funct[2]) begin
                ctrl.bSel = exPkg::B_SHIFTVAR;
            end else begin
                ctrl.bSel = exPkg::B_SHIFTCONST;
            end
        end else if (!special) begin
            ctrl.bSel = exPkg::B_IMM;      // every non-special op takes the immediate
        end else begin
            ctrl.bSel = exPkg::B_RT;
        end

        // ALU op; loads, stores and unknown codes fall back to add
        ctrl.aluOp = exPkg::ALU_ADD;
        if (shift) begin
            if (!funct[1]) begin
                ctrl.aluOp = exPkg::ALU_SLL;
            end else if (funct[0]) begin
                ctrl.aluOp = exPkg::ALU_SRA;
            end else begin
                ctrl.aluOp = exPkg::ALU_SRL;
            end
        end else if (special) begin
            case (funct)
                `FN_ADDU: ctrl.aluOp = exPkg::ALU_ADD;
                `FN_SUB:  ctrl.aluOp = exPkg::ALU_SUB;
                `FN_AND:  ctrl.aluOp = exPkg::ALU_AND;
                `FN_OR:   ctrl.aluOp = exPkg::ALU_OR;
                `FN_NOR:  ctrl.aluOp = exPkg::ALU_NOR;
                `FN_XOR:  ctrl.aluOp = exPkg::ALU_XOR;
                `FN_SLTU: ctrl.aluOp = exPkg::ALU_SLTU;
                `FN_SLT:  ctrl.aluOp = exPkg::ALU_SLT;
                default:  ctrl.aluOp = exPkg::ALU_ADD;
            endcase
        end else begin
            case (opcode)
                `OP_ADDIU: ctrl.aluOp = exPkg::ALU_ADD;
                `OP_ANDI:  ctrl.aluOp = exPkg::ALU_AND;
                `OP_ORI:   ctrl.aluOp = exPkg::ALU_OR;
                `OP_XORI:  ctrl.aluOp = exPkg::ALU_XOR;
                `OP_SLTIU: ctrl.aluOp = exPkg::ALU_SLTU;
                `OP_SLTI:  ctrl.aluOp = exPkg::ALU_SLT;
                default:   ctrl.aluOp = exPkg::ALU_ADD;   // lw/sw etc
            endcase
        end

        // mul/div controls straight from funct bits
        if (mdGroup) begin
            ctrl.md.launch     = funct[3];
            ctrl.md.divide     = funct[1];
            ctrl.md.isUnsigned = funct[0];
            ctrl.md.moveTo     = !funct[3] && funct[0];
            ctrl.md.targetLo   = funct[1];
            ctrl.readsMd       = !funct[3] && !funct[0];   // mfhi/mflo
        end

        // mfhi/mflo always from HI/LO, otherwise DO wins when it is already known
        if (ctrl.readsMd) begin
            ctrl.resSel = exPkg::RES_MULDIV;
        end else if (doReliable) begin
            ctrl.resSel = exPkg::RES_DO;
        end else begin
            ctrl.resSel = exPkg::RES_ALU;
        end
    end

    // launches write no register; R-type uses rd, the rest rt
    assign dest = (mdGroup && funct[3]) ? 5'd0 :
                  special               ? inst[`RD] : inst[`RT];

endmodule

`default_nettype wire

/* src/exAlu.sv */
// combinational ALU with operand selection, produces aluY for the result stage
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module exAlu (
    input  wire exPkg::exCtrlT ctrl,
    input  wire logic [31:0]   rsVal,
    input  wire logic [31:0]   rtVal,
    input  wire logic [31:0]   immExt,
    input  wire logic [31:0]   inst,
    output logic [31:0]        y
);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;      // shift amount, low bits of A

    // A is rs or zero-extended shamt
    assign a = (ctrl.aSel == exPkg::A_SHAMT) ? {27'b0, inst[`SHAMT]} : rsVal;

    // rt for R-type and both shift kinds
    assign b = (ctrl.bSel == exPkg::B_IMM) ? immExt : rtVal;

    assign sh = a[4:0];

    always_comb begin
        case (ctrl.aluOp)
            exPkg::ALU_ADD: begin
                y = a + b;
            end
            exPkg::ALU_SUB: begin
                y = a - b;          // wraps, no trap
            end
            exPkg::ALU_AND: begin
                y = a & b;
            end
            exPkg::ALU_OR: begin
                y = a | b;
            end
            exPkg::ALU_NOR: begin
                y = ~(a | b);
            end
            exPkg::ALU_XOR: begin
                y = a ^ b;
            end
            exPkg::ALU_SLL: begin
                y = b << sh;
            end
            exPkg::ALU_SRA: begin
                y = $signed(b) >>> sh;   // sign fill
            end
            exPkg::ALU_SRL: begin
                y = b >> sh;
            end
            exPkg::ALU_SLTU: begin
                y = {31'b0, a < b};
            end
            exPkg::ALU_SLT: begin
                y = {31'b0, $signed(a) < $signed(b)};
            end
            default: begin
                y = a + b;          // codes 11..15 unused
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/exMulDiv.sv */
// multi-cycle multiply/divide unit with HI/LO, stalls mul/div-group instructions while busy
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module exMulDiv (
    input  wire logic          clk,
    input  wire logic          arstN,
    input  wire logic          accept,    // instruction taken this edge
    input  wire logic          valid,
    input  wire exPkg::mdCtrlT md,
    input  wire logic          readsMd,
    input  wire logic [31:0]   rsVal,
    input  wire logic [31:0]   rtVal,
    output logic               busy,
    output logic               stall,
    output logic [31:0]        y
);
    localparam int CntW = $clog2(`DIV_CYCLES + 1);

    logic [CntW-1:0]    cnt;          // cycles left, 0 = idle
    logic               done;         // last busy cycle
    logic [31:0]        opA;          // latched rs
    logic [31:0]        opB;          // latched rt
    logic               opDivide;
    logic               opUnsigned;
    logic [31:0]        hi;
    logic [31:0]        lo;
    logic signed [63:0] prodS;
    logic [63:0]        prodU;
    logic [31:0]        resHi;
    logic [31:0]        resLo;

    assign busy = (cnt != '0);
    assign done = (cnt == CntW'(1));

    // only mul/div-group ops wait, everything else flows past a busy unit
    assign stall = busy && valid && (md.launch || md.moveTo || readsMd);

    // outcome of the latched operation, written when busy falls
    always_comb begin
        prodS = 64'($signed(opA)) * 64'($signed(opB));
        prodU = {32'b0, opA} * {32'b0, opB};
        if (!opDivide) begin
            if (opUnsigned) begin
                {resHi, resLo} = prodU;
            end else begin
                {resHi, resLo} = prodS;
            end
        end else if (opB == '0) begin
            resLo = '1;                       // divide by zero
            resHi = opA;
        end else if (opUnsigned) begin
            resLo = opA / opB;
            resHi = opA % opB;
        end else if (opA == 32'h8000_0000 && opB == '1) begin
            resLo = opA;                      // -2^31 / -1 wraps
            resHi = '0;
        end else begin
            resLo = $signed(opA) / $signed(opB);   // truncates toward zero
            resHi = $signed(opA) % $signed(opB);   // sign of dividend
        end
    end

    // countdown and HI/LO
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cnt <= '0;
            hi  <= '0;
            lo  <= '0;
        end else begin
            if (accept && md.launch) begin
                cnt <= md.divide ? CntW'(`DIV_CYCLES) : CntW'(`MUL_CYCLES);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end

            if (done) begin
                hi <= resHi;
                lo <= resLo;
            end else if (accept && md.moveTo) begin   // never while busy, stalled
                if (md.targetLo) begin
                    lo <= rsVal;
                end else begin
                    hi <= rsVal;
                end
            end
        end
    end

    // operand capture at launch
    always_ff @(posedge clk) begin
        if (accept && md.launch) begin
            opA        <= rsVal;
            opB        <= rtVal;
            opDivide   <= md.divide;
            opUnsigned <= md.isUnsigned;
        end
    end

    assign y = md.targetLo ? lo : hi;   // mflo / mfhi

endmodule

`default_nettype wire

/* src/exResult.sv */
// result source select and EX/MEM register, one outValid pulse per accepted instruction
`timescale 1ns/1ps
`default_nettype none

module exResult (
    input  wire logic           clk,
    input  wire logic           arstN,
    input  wire logic           valid,
    input  wire logic           stall,     // from mul/div unit
    input  wire exPkg::resSelE  resSel,
    input  wire logic [31:0]    aluY,
    input  wire logic [31:0]    doVal,
    input  wire logic [31:0]    mdY,
    input  wire logic [4:0]     dest,
    output logic                accept,
    output logic                outValid,
    output exPkg::exOutT        out
);
    logic [31:0] resY;

    assign accept = valid && !stall;

    always_comb begin
        case (resSel)
            exPkg::RES_DO:     resY = doVal;
            exPkg::RES_MULDIV: resY = mdY;
            default:           resY = aluY;
        endcase
    end

    // pulse, cleared on any cycle without accept
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= accept;
        end
    end

    // payload holds when nothing is accepted
    always_ff @(posedge clk) begin
        if (accept) begin
            out.result <= resY;
            out.dest   <= dest;
        end
    end

endmodule

`default_nettype wire

/* src/exStage.sv */
// execute stage top, connects decoder, ALU, mul/div unit and result register
`timescale 1ns/1ps
`default_nettype none

module exStage (
    input  wire logic         clk,
    input  wire logic         arstN,
    input  wire logic         inValid,
    input  wire exPkg::exInT  in,
    input  wire logic         doReliable,
    output logic              stall,       // hold inValid and in while high
    output logic              outValid,
    output exPkg::exOutT      out
);
    exPkg::exCtrlT ctrl;
    logic [4:0]    dest;
    logic [31:0]   aluY;
    logic [31:0]   mdY;
    logic          accept;

    exDecode uDecode (
        .inst       (in.inst),
        .doReliable (doReliable),
        .ctrl       (ctrl),
        .dest       (dest)
    );

    exAlu uAlu (
        .ctrl   (ctrl),
        .rsVal  (in.rsVal),
        .rtVal  (in.rtVal),
        .immExt (in.immExt),
        .inst   (in.inst),
        .y      (aluY)
    );

    exMulDiv uMulDiv (
        .clk     (clk),
        .arstN   (arstN),
        .accept  (accept),
        .valid   (inValid),
        .md      (ctrl.md),
        .readsMd (ctrl.readsMd),
        .rsVal   (in.rsVal),
        .rtVal   (in.rtVal),
        .busy    (),
        .stall   (stall),      // stage stall is the mul/div stall
        .y       (mdY)
    );

    exResult uResult (
        .clk      (clk),
        .arstN    (arstN),
        .valid    (inValid),
        .stall    (stall),
        .resSel   (ctrl.resSel),
        .aluY     (aluY),
        .doVal    (in.doVal),
        .mdY      (mdY),
        .dest     (dest),
        .accept   (accept),
        .outValid (outValid),
        .out      (out)
    );

endmodule

`default_nettype wire

/* test/tbExModel.svh */
// reference model of the execute stage, included inside the testbench module after ex_defs.svh
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// mult, multu, div, divu
function automatic logic modelLaunch(input logic [31:0] inst);
    return (inst[`OPCODE] == `OP_SPECIAL) &&
           (inst[`FUNCT] inside {`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU});
endfunction

// result defined for everything except launches and moves
function automatic logic modelCares(input logic [31:0] inst);
    if (modelLaunch(inst))
        return 1'b0;
    return !((inst[`OPCODE] == `OP_SPECIAL) && (inst[`FUNCT] inside {`FN_MTHI, `FN_MTLO}));
endfunction

function automatic logic [4:0] modelDest(input logic [31:0] inst);
    if (modelLaunch(inst))
        return 5'd0;                       // launches write no register
    return (inst[`OPCODE] == `OP_SPECIAL) ? inst[`RD] : inst[`RT];
endfunction

// two's complement compare from the sign bits
function automatic logic lessSigned(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
endfunction

function automatic logic [31:0] modelAlu(input logic [31:0] inst, rs, rt, imm);
    logic [63:0] sraC;     // sign-filled rt shifted by shamt
    logic [63:0] sraV;     // same, amount from rs
    sraC = {{32{rt[31]}}, rt} >> inst[`SHAMT];
    sraV = {{32{rt[31]}}, rt} >> rs[4:0];
    if (inst[`OPCODE] != `OP_SPECIAL) begin
        case (inst[`OPCODE])
            `OP_ANDI:  return rs & imm;
            `OP_ORI:   return rs | imm;
            `OP_XORI:  return rs ^ imm;
            `OP_SLTI:  return {31'b0, lessSigned(rs, imm)};
            `OP_SLTIU: return {31'b0, rs < imm};
            default:   return rs + imm;        // addiu, loads, stores
        endcase
    end
    case (inst[`FUNCT])
        `FN_SUB:  return rs - rt;
        `FN_AND:  return rs & rt;
        `FN_OR:   return rs | rt;
        `FN_XOR:  return rs ^ rt;
        `FN_NOR:  return ~(rs | rt);
        `FN_SLT:  return {31'b0, lessSigned(rs, rt)};
        `FN_SLTU: return {31'b0, rs < rt};
        `FN_SLL:  return rt << inst[`SHAMT];
        `FN_SRL:  return rt >> inst[`SHAMT];
        `FN_SRA:  return sraC[31:0];
        `FN_SLLV: return rt << rs[4:0];
        `FN_SRLV: return rt >> rs[4:0];
        `FN_SRAV: return sraV[31:0];
        default:  return rs + rt;              // addu
    endcase
endfunction

// {HI, LO} after a launch
function automatic logic [63:0] modelHiLo(input logic [5:0] fn, input logic [31:0] a, b);
    logic [31:0] ma;
    logic [31:0] mb;
    logic [31:0] q;
    logic [31:0] r;
    if (fn == `FN_MULT)
        return {{32{a[31]}}, a} * {{32{b[31]}}, b};   // low 64 bits of sign-extended product
    if (fn == `FN_MULTU)
        return {32'b0, a} * {32'b0, b};
    if (b == 32'b0)
        return {a, 32'hFFFF_FFFF};                   // divide by zero
    if (fn == `FN_DIVU)
        return {a % b, a / b};
    ma = a[31] ? -a : a;                             // magnitudes, then fix signs
    mb = b[31] ? -b : b;
    q  = ma / mb;
    r  = ma % mb;
    if (a[31] != b[31])
        q = -q;
    if (a[31])
        r = -r;                                      // remainder follows the dividend
    return {r, q};
endfunction

function automatic logic [31:0] modelResult(input logic [31:0] inst, rs, rt, imm, dov,
                                            input logic dor, input logic [31:0] hi, lo);
    if ((inst[`OPCODE] == `OP_SPECIAL) && (inst[`FUNCT] == `FN_MFHI))
        return hi;
    if ((inst[`OPCODE] == `OP_SPECIAL) && (inst[`FUNCT] == `FN_MFLO))
        return lo;
    if (dor)
        return dov;                                  // forwarded value wins
    return modelAlu(inst, rs, rt, imm);
endfunction

`endif

/* test/tbExStage.sv */
// testbench for the execute stage, LFSR-driven instructions checked against tbExModel.svh
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module tbExStage;
    `include "tbExModel.svh"

    localparam int numInstr = 200;        // upper bound over all tests
    localparam int limitNs  = numInstr * (`DIV_CYCLES + 2) * 40 + 16 * 40;
    localparam logic [5:0] aluFns [8] = '{`FN_ADDU, `FN_SUB, `FN_AND, `FN_OR,
                                          `FN_NOR, `FN_XOR, `FN_SLT, `FN_SLTU};
    localparam logic [5:0] immOps [6] = '{`OP_ADDIU, `OP_ANDI, `OP_ORI,
                                          `OP_XORI, `OP_SLTI, `OP_SLTIU};
    localparam logic [5:0] shiftFns [6] = '{`FN_SLL, `FN_SRL, `FN_SRA,
                                            `FN_SLLV, `FN_SRLV, `FN_SRAV};
    localparam logic [5:0] mdFns [4] = '{`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU};

    logic         clk;
    logic         arstN;
    logic         inValid;
    exPkg::exInT  inBus;
    logic         doReliable;
    logic         stall;
    logic         outValid;
    exPkg::exOutT outBus;
    logic [31:0]  lfsr;
    logic [31:0]  hiM;          // model HI/LO
    logic [31:0]  loM;
    logic         expValid;     // outValid due at next negedge
    logic         expCare;
    logic [31:0]  expRes;
    logic [4:0]   expDest;
    int           errors;
    int           checks;
    int           tests;

    exStage dut (
        .clk        (clk),
        .arstN      (arstN),
        .inValid    (inValid),
        .in         (inBus),
        .doReliable (doReliable),
        .stall      (stall),
        .outValid   (outValid),
        .out        (outBus)
    );

    always #20 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] randR(input logic [5:0] fn);
        logic [31:0] f;
        f = randBits(20);                  // rs, rt, rd, shamt
        return {`OP_SPECIAL, f[19:0], fn};
    endfunction

    function automatic logic [31:0] randI(input logic [5:0] op);
        logic [31:0] f;
        f = randBits(26);
        return {op, f[25:0]};
    endfunction

    // zero extension for logic ops and sign extension otherwise, as the previous stage does
    function automatic logic [31:0] immOf(input logic [31:0] inst);
        logic [15:0] i;
        i = inst[`IMM];
        if (inst[`OPCODE] inside {`OP_ANDI, `OP_ORI, `OP_XORI})
            return {16'b0, i};
        return {{16{i[15]}}, i};
    endfunction

    function automatic logic [31:0] randAluInst();
        int k;
        k = randBits(2);
        if (k < 2)
            return randR(aluFns[randBits(3)]);
        if (k == 2)
            return randI(immOps[randBits(3) % 6]);
        return randI({`LDST_TOP, 4'(randBits(4))});   // load or store
    endfunction

    // drive at posedge, hold while stalled; returns on the negedge before acceptance
    task automatic issue(input logic [31:0] inst, rs, rt, imm, dov, input logic dor,
                         output logic stalled);
        @(posedge clk);
        inValid    <= 1'b1;
        inBus      <= {inst, rs, rt, imm, dov};    // field order of exInT
        doReliable <= dor;
        stalled = 1'b0;
        @(negedge clk);
        while (stall) begin
            stalled = 1'b1;
            @(negedge clk);
        end
    endtask

    task automatic issueRand(input logic [31:0] inst, input logic dor, output logic stalled);
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] dov;
        rs  = randBits(32);
        rt  = randBits(32);
        dov = randBits(32);
        issue(inst, rs, rt, immOf(inst), dov, dor, stalled);
    endtask

    task automatic finishTest(input string name, input int errStart);
        @(posedge clk);
        inValid <= 1'b0;
        repeat (3) @(negedge clk);        // let the last result drain
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errStart);
    endtask

    // scoreboard holding one pending result at most
    always @(negedge clk) begin
        if (arstN) begin
            if (outValid !== expValid) begin
                $display("error t=%0t outValid got %b exp %b", $time, outValid, expValid);
                errors++;
            end else if (expValid) begin
                checks++;
                if (expCare && outBus.result !== expRes) begin
                    $display("error t=%0t out.result got %h exp %h",
                             $time, outBus.result, expRes);
                    errors++;
                end
                if (outBus.dest !== expDest) begin
                    $display("error t=%0t out.dest got %0d exp %0d", $time, outBus.dest, expDest);
                    errors++;
                end
            end
            expValid = inValid && !stall;  // taken at the coming posedge
            if (expValid) begin
                expRes  = modelResult(inBus.inst, inBus.rsVal, inBus.rtVal, inBus.immExt,
                                      inBus.doVal, doReliable, hiM, loM);
                expCare = modelCares(inBus.inst);
                expDest = modelDest(inBus.inst);
                if (modelLaunch(inBus.inst))
                    {hiM, loM} = modelHiLo(inBus.inst[`FUNCT], inBus.rsVal, inBus.rtVal);
                else if (inBus.inst[`OPCODE] == `OP_SPECIAL && inBus.inst[`FUNCT] == `FN_MTHI)
                    hiM = inBus.rsVal;
                else if (inBus.inst[`OPCODE] == `OP_SPECIAL && inBus.inst[`FUNCT] == `FN_MTLO)
                    loM = inBus.rsVal;
            end
        end
    end

    initial begin
        #(limitNs);
        $display("timeout: run did not finish within %0d ns", limitNs);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int          e0;
        int          k;
        logic        st;
        logic [31:0] a;
        logic [31:0] b;
        logic [5:0]  fn;
        clk        = 1'b0;
        arstN      = 1'b0;
        inValid    = 1'b0;
        inBus      = '0;
        doReliable = 1'b0;
        lfsr       = 32'd71046;
        hiM        = '0;
        loM        = '0;
        expValid   = 1'b0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;

        e0 = errors;
        repeat (40) issueRand(randAluInst(), 1'b0, st);
        finishTest("alu reg/imm", e0);

        e0 = errors;
        repeat (24) issueRand(randR(shiftFns[randBits(3) % 6]), 1'b0, st);
        finishTest("shifts", e0);

        e0 = errors;
        issueRand(randR(`FN_MFHI), 1'b0, st);     // zero after reset
        issueRand(randR(`FN_MFLO), 1'b0, st);
        repeat (12) begin
            fn = mdFns[randBits(2)];
            a  = randBits(32);
            b  = randBits(32);
            if (fn[1] && randBits(2) == 0)
                b = '0;                           // divide by zero now and then
            issue(randR(fn), a, b, '0, '0, 1'b0, st);
            issueRand(randR(`FN_MFHI), 1'b0, st);
            if (!st) begin
                $display("mfhi right after a launch was accepted without a stall");
                errors++;
            end
            issueRand(randR(`FN_MFLO), 1'b0, st);
        end
        // divide by zero both ways, then the signed overflow case
        issue(randR(`FN_DIV), randBits(32), '0, '0, '0, 1'b0, st);
        issueRand(randR(`FN_MFHI), 1'b0, st);
        issueRand(randR(`FN_MFLO), 1'b0, st);
        issue(randR(`FN_DIVU), randBits(32), '0, '0, '0, 1'b0, st);
        issueRand(randR(`FN_MFHI), 1'b0, st);
        issueRand(randR(`FN_MFLO), 1'b0, st);
        issue(randR(`FN_DIV), 32'h8000_0000, 32'hFFFF_FFFF, '0, '0, 1'b0, st);
        issueRand(randR(`FN_MFHI), 1'b0, st);
        issueRand(randR(`FN_MFLO), 1'b0, st);
        finishTest("mul/div", e0);

        e0 = errors;
        repeat (6) begin
            issue(randR(mdFns[2 + randBits(1)]), randBits(32), randBits(32), '0, '0, 1'b0, st);
            issue(randR(`FN_MTHI), randBits(32), randBits(32), '0, '0, 1'b0, st);
            issue(randR(`FN_MTLO), randBits(32), randBits(32), '0, '0, 1'b0, st);
            issueRand(randR(`FN_MFHI), 1'b0, st);
            issueRand(randR(`FN_MFLO), 1'b0, st);
        end
        finishTest("move to hi/lo", e0);

        e0 = errors;
        repeat (16) begin
            k = randBits(2);
            if (k == 0)
                issueRand(randR(randBits(1) ? `FN_MFHI : `FN_MFLO), 1'b1, st);
            else if (k == 1)
                issueRand(randR(shiftFns[randBits(3) % 6]), 1'b1, st);
            else
                issueRand(randAluInst(), 1'b1, st);
        end
        finishTest("do bypass", e0);

        e0 = errors;
        repeat (4) begin
            issue(randR(`FN_DIV), randBits(32), randBits(32), '0, '0, 1'b0, st);
            repeat (8) begin
                issueRand(randAluInst(), 1'b0, st);
                if (st) begin
                    $display("ALU instruction was stalled while the mul/div unit was busy");
                    errors++;
                end
            end
            issueRand(randR(`FN_MFLO), 1'b0, st);
        end
        finishTest("stall scope", e0);

        $display("summary: %0d tests, %0d results checked, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+src
+incdir+test
src/exPkg.sv
src/exDecode.sv
src/exAlu.sv
src/exMulDiv.sv
src/exResult.sv
src/exStage.sv
test/tbExStage.sv

/* run.sh */
#!/bin/sh
# compile the execute stage testbench with Verilator, run it, pass only on the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f flist.f --top-module tbExStage -o simExStage
out=$(./obj_dir/simExStage)
echo "$out"
echo "$out" | grep -Fqx "Done: no errors"
